// File: all.f
+incdir+include
hdl/sha256_pkg.sv
hdl/sha256_ctl_if.sv
hdl/sha256_ctrl.sv
hdl/sha256_msg_sched.sv
hdl/sha256_round.sv
hdl/sha256_hash_regs.sv
hdl/sha256_core.sv
dv/tb_sha256.sv

// File: dv/tb_sha256.sv
`default_nettype none

`include "sha256_cfg.svh"

module tb_sha256;
  timeunit 1ns;
  timeprecision 1ps;

  import sha256_pkg::*;

  localparam int WW             = `SHA_WORD_W;
  localparam int RESET_CYCLES   = 10;
  localparam int LATENCY        = 67;  // INIT_HASH + LOAD + 64 rounds + UPDATE
  localparam int MAX_REQUESTS   = 40;
  localparam int CYCLES_PER_REQ = 100;
  localparam int TIMEOUT_CYCLES = MAX_REQUESTS * CYCLES_PER_REQ + RESET_CYCLES;
  localparam logic [31:0] SEED  = 32'h1a50_44a2;

  // FIPS 180-4 initial hash value
  localparam digest_t IV_REF = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  // "abc" padded to one block with a 24-bit length
  localparam block_t ABC_BLOCK = {32'h61626380, {14{32'h0}}, 32'h00000018};
  localparam digest_t ABC_DIGEST = {
    32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
    32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
  };

  logic    clk;
  logic    n_reset;
  logic    req;
  logic    first;
  block_t  blk_in;
  logic    ack;
  digest_t digest;

  logic [31:0] lfsr_state = SEED;
  digest_t     exp_digest = '0;  // what the next ack must show
  digest_t     chain_hash = '0;
  logic        ack_q = 1'b0;
  int          err_count = 0;
  int          check_count = 0;
  int          acks_checked = 0;
  int          requests_done = 0;
  int          cycle_count = 0;

  sha256_core dut_i (
    .i_clk     (clk),
    .i_n_reset (n_reset),
    .i_req     (req),
    .i_first   (first),
    .i_block   (blk_in),
    .o_ack     (ack),
    .o_digest  (digest)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic word_t rotate_right(word_t x, int n);
    return (x >> n) | (x << (WW - n));
  endfunction

  // one compression of blk into hv as the standard defines it
  function automatic digest_t sha_compress(digest_t hv, block_t blk);
    word_t   w [64];
    word_t   v [8];
    word_t   s0, s1, t1, t2;
    digest_t res;
    for (int t = 0; t < 16; t++)
      w[t] = blk[(15 - t)*WW +: WW];
    for (int t = 16; t < 64; t++) begin
      s0 = rotate_right(w[t-15], 7) ^ rotate_right(w[t-15], 18) ^ (w[t-15] >> 3);
      s1 = rotate_right(w[t-2], 17) ^ rotate_right(w[t-2], 19) ^ (w[t-2] >> 10);
      w[t] = s1 + w[t-7] + s0 + w[t-16];
    end
    for (int i = 0; i < 8; i++)
      v[i] = hv[(7 - i)*WW +: WW];
    for (int t = 0; t < 64; t++) begin
      s1 = rotate_right(v[4], 6) ^ rotate_right(v[4], 11) ^ rotate_right(v[4], 25);
      t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + SHA_K[t] + w[t];
      s0 = rotate_right(v[0], 2) ^ rotate_right(v[0], 13) ^ rotate_right(v[0], 22);
      t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      for (int i = 7; i > 0; i--)
        v[i] = v[i-1];
      v[4] = v[4] + t1;  // v[4] holds the old d here
      v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++)
      res[(7 - i)*WW +: WW] = hv[(7 - i)*WW +: WW] + v[i];
    return res;
  endfunction

  task automatic check_value(input logic [255:0] got, input logic [255:0] exp,
                             input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic random_block(output block_t blk);
    for (int i = 0; i < $bits(block_t); i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      blk[i] = lfsr_state[0];
    end
  endtask

  // full four-phase transfer with req kept up for hold cycles after ack
  task automatic run_request(input logic is_first, input block_t blk,
                             input digest_t expected, input int hold);
    digest_t held;
    int      lat;
    exp_digest = expected;
    @(negedge clk);
    req = 1'b1;
    first = is_first;
    blk_in = blk;
    lat = 0;
    @(negedge clk);  // the rising edge just before samples req in IDLE
    while (!ack) begin
      @(negedge clk);
      lat++;
    end
    check_value(256'(lat), 256'(LATENCY), "request to ack latency");
    held = digest;
    repeat (hold) begin
      @(negedge clk);
      check_value(256'(ack), 256'(1), "ack while req held");
      check_value(digest, held, "digest while req held");
    end
    req = 1'b0;
    @(negedge clk);
    check_value(256'(ack), 256'(0), "ack one cycle after req drop");
    chain_hash = expected;
    requests_done++;
  endtask

  // compares the digest on every rising ack
  always @(posedge clk) begin
    if (ack && !ack_q) begin
      check_value(digest, exp_digest, "digest at ack");
      acks_checked++;
    end
    ack_q = ack;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    block_t blk;
    n_reset = 1'b0;
    req = 1'b0;
    first = 1'b0;
    blk_in = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    check_value(256'(ack), 256'(0), "ack in reset");
    n_reset = 1'b1;
    @(negedge clk);
    check_value(256'(ack), 256'(0), "ack after reset");

    check_value(sha_compress(IV_REF, ABC_BLOCK), ABC_DIGEST, "reference model on abc");
    run_request(1'b1, ABC_BLOCK, ABC_DIGEST, 0);

    repeat (20) begin
      random_block(blk);
      run_request(1'b1, blk, sha_compress(IV_REF, blk), 0);
    end

    // four-block message chained through H
    random_block(blk);
    run_request(1'b1, blk, sha_compress(IV_REF, blk), 0);
    repeat (3) begin
      random_block(blk);
      run_request(1'b0, blk, sha_compress(chain_hash, blk), 0);
    end

    random_block(blk);
    run_request(1'b1, blk, sha_compress(IV_REF, blk), 20);

    // reset lands in the middle of the rounds
    random_block(blk);
    @(negedge clk);
    req = 1'b1;
    first = 1'b1;
    blk_in = blk;
    repeat (30) @(negedge clk);
    n_reset = 1'b0;
    req = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    check_value(256'(ack), 256'(0), "ack after mid-run reset");
    check_value(digest, '0, "digest after mid-run reset");
    n_reset = 1'b1;
    random_block(blk);
    run_request(1'b1, blk, sha_compress(IV_REF, blk), 0);

    check_value(256'(acks_checked), 256'(requests_done), "acks seen by the checker");
    $display("errors: %0d mismatches in %0d checks, %0d requests", err_count, check_count,
             requests_done);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/sha256_core.sv
`default_nettype none

module sha256_core (
  input  wire logic                i_clk,
  input  wire logic                i_n_reset,
  input  wire logic                i_req,
  input  wire logic                i_first,
  input  wire sha256_pkg::block_t  i_block,
  output logic                     o_ack,
  output sha256_pkg::digest_t      o_digest
);
  import sha256_pkg::*;

  word_t   w;     // schedule word for the current round
  digest_t hash;  // chaining value H0..H7
  digest_t work;  // a..h after the last round

  sha256_ctl_if u_ctl_if ();

  sha256_ctrl u_ctrl (
    .i_clk     (i_clk),
    .i_n_reset (i_n_reset),
    .i_req     (i_req),
    .o_ack     (o_ack),
    .ctl       (u_ctl_if.ctrl)
  );

  sha256_hash_regs u_hash_regs (
    .i_clk     (i_clk),
    .i_n_reset (i_n_reset),
    .i_first   (i_first),
    .ctl       (u_ctl_if.hregs),
    .i_work    (work),
    .o_hash    (hash)
  );

  sha256_msg_sched u_msg_sched (
    .i_clk     (i_clk),
    .i_n_reset (i_n_reset),
    .i_block   (i_block),
    .ctl       (u_ctl_if.sched),
    .o_w       (w)
  );

  sha256_round u_round (
    .i_clk     (i_clk),
    .i_n_reset (i_n_reset),
    .ctl       (u_ctl_if.round),
    .i_w       (w),
    .i_hash    (hash),
    .o_work    (work)
  );

  assign o_digest = hash;

endmodule

`default_nettype wire

// File: hdl/sha256_ctl_if.sv
`default_nettype none

// strobes from the phase sequencer to the datapath
interface sha256_ctl_if;
  import sha256_pkg::*;

  logic       init_hash;  // H <= IV when the request is a first block
  logic       load;       // window <= block, a..h <= H
  logic       step;       // one round per cycle
  round_idx_t round_idx;
  logic       update;     // H <= H + a..h

  modport ctrl (output init_hash, load, step, round_idx, update);
  modport sched (input load, step);
  modport round (input load, step, round_idx);
  modport hregs (input init_hash, update);

endinterface

`default_nettype wire

// File: hdl/sha256_ctrl.sv
`default_nettype none

`include "sha256_cfg.svh"

module sha256_ctrl (
  input  wire logic  i_clk,
  input  wire logic  i_n_reset,
  input  wire logic  i_req,
  output logic       o_ack,
  sha256_ctl_if.ctrl ctl
);
  import sha256_pkg::*;

  localparam round_idx_t LAST_ROUND = round_idx_t'(`SHA_ROUNDS - 1);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  round_idx_t  round_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (i_req) state_d = INIT_HASH;
      INIT_HASH: state_d = LOAD;
      LOAD:      state_d = ROUND;
      ROUND:     if (round_q == LAST_ROUND) state_d = UPDATE;
      UPDATE:    state_d = ACK;
      ACK:       if (!i_req) state_d = IDLE;  // hold while the host keeps req up
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_n_reset) begin
    if (!i_n_reset) begin
      state_q <= IDLE;
      round_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ROUND)
        round_q <= round_q + round_idx_t'(1);  // wraps back to 0 after the last round
    end
  end

  // phase decode
  assign ctl.init_hash = (state_q == INIT_HASH);
  assign ctl.load      = (state_q == LOAD);
  assign ctl.step      = (state_q == ROUND);
  assign ctl.update    = (state_q == UPDATE);
  assign ctl.round_idx = round_q;
  assign o_ack         = (state_q == ACK);

  a_step_alone: assert property (@(posedge i_clk) disable iff (!i_n_reset)
    ctl.step |-> !(ctl.load || ctl.update));

  // the digest must be folded in before the host sees ack
  a_ack_after_update: assert property (@(posedge i_clk) disable iff (!i_n_reset)
    $rose(o_ack) |-> $past(state_q == UPDATE));

  a_idx_wrap: assert property (@(posedge i_clk) disable iff (!i_n_reset)
    (ctl.round_idx == '0 && $past(ctl.round_idx) != '0)
      |-> $past(ctl.step && ctl.round_idx == LAST_ROUND));

endmodule

`default_nettype wire

// File: hdl/sha256_hash_regs.sv
`default_nettype none

`include "sha256_cfg.svh"

module sha256_hash_regs (
  input  wire logic                i_clk,
  input  wire logic                i_n_reset,
  input  wire logic                i_first,
  sha256_ctl_if.hregs              ctl,
  input  wire sha256_pkg::digest_t i_work,
  output sha256_pkg::digest_t      o_hash
);
  import sha256_pkg::*;

  digest_t h_q;
  digest_t h_sum;

  // word-wise add, no carry between H words
  always_comb begin
    for (int i = 0; i < `SHA_DIGEST_WORDS; i++)
      h_sum[i*`SHA_WORD_W +: `SHA_WORD_W] = h_q[i*`SHA_WORD_W +: `SHA_WORD_W]
                                          + i_work[i*`SHA_WORD_W +: `SHA_WORD_W];
  end

  always_ff @(posedge i_clk or negedge i_n_reset) begin
    if (!i_n_reset)
      h_q <= '0;
    else if (ctl.init_hash && i_first)
      h_q <= SHA_IV;  // new message
    else if (ctl.update)
      h_q <= h_sum;
  end

  assign o_hash = h_q;

  a_no_overlap: assert property (@(posedge i_clk) disable iff (!i_n_reset)
    !(ctl.update && ctl.init_hash));

endmodule

`default_nettype wire

// File: hdl/sha256_msg_sched.sv
`default_nettype none

`include "sha256_cfg.svh"

module sha256_msg_sched (
  input  wire logic             i_clk,
  input  wire logic             i_n_reset,
  input  wire sha256_pkg::block_t i_block,
  sha256_ctl_if.sched           ctl,
  output sha256_pkg::word_t     o_w
);
  import sha256_pkg::*;

  localparam int LAST = `SHA_BLOCK_WORDS - 1;

  word_t w_q [`SHA_BLOCK_WORDS];  // w_q[0] holds W[t]
  word_t w_next;

  function automatic word_t gamma0(word_t x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic word_t gamma1(word_t x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  // W[t+16] from W[t+14], W[t+9], W[t+1] and W[t]
  assign w_next = gamma1(w_q[14]) + w_q[9] + gamma0(w_q[1]) + w_q[0];

  always_ff @(posedge i_clk or negedge i_n_reset) begin
    if (!i_n_reset) begin
      for (int i = 0; i < `SHA_BLOCK_WORDS; i++)
        w_q[i] <= '0;
    end else if (ctl.load) begin
      for (int i = 0; i < `SHA_BLOCK_WORDS; i++)
        w_q[i] <= i_block[(LAST - i)*`SHA_WORD_W +: `SHA_WORD_W];  // big endian word order
    end else if (ctl.step) begin
      for (int i = 0; i < LAST; i++)
        w_q[i] <= w_q[i+1];
      w_q[LAST] <= w_next;
    end
  end

  assign o_w = w_q[0];

endmodule

`default_nettype wire

// File: hdl/sha256_pkg.sv
`default_nettype none

`include "sha256_cfg.svh"

package sha256_pkg;

  typedef logic [`SHA_WORD_W-1:0] word_t;
  typedef logic [`SHA_BLOCK_WORDS*`SHA_WORD_W-1:0] block_t;   // word 0 in the msbs
  typedef logic [`SHA_DIGEST_WORDS*`SHA_WORD_W-1:0] digest_t; // H0 in the msbs
  typedef logic [$clog2(`SHA_ROUNDS)-1:0] round_idx_t;

  typedef enum logic [2:0] {
    IDLE,
    INIT_HASH,
    LOAD,
    ROUND,
    UPDATE,
    ACK
  } ctrl_state_t;

  // round constants, first 32 bits of the fractional parts of the cube roots of the primes
  localparam word_t SHA_K [`SHA_ROUNDS] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // initial hash value H0..H7
  localparam digest_t SHA_IV = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  // rotate right, shared by the schedule and the round function
  function automatic word_t rotr(word_t x, int unsigned n);
    return (x >> n) | (x << (`SHA_WORD_W - n));
  endfunction

endpackage

`default_nettype wire

// File: hdl/sha256_round.sv
`default_nettype none

module sha256_round (
  input  wire logic                i_clk,
  input  wire logic                i_n_reset,
  sha256_ctl_if.round              ctl,
  input  wire sha256_pkg::word_t   i_w,
  input  wire sha256_pkg::digest_t i_hash,
  output sha256_pkg::digest_t      o_work
);
  import sha256_pkg::*;

  word_t a, b, c, d, e, f, g, h;  // working registers
  word_t t1;
  word_t t2;

  function automatic word_t sigma0(word_t x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic word_t sigma1(word_t x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  function automatic word_t ch(word_t x, word_t y, word_t z);
    return (x & y) ^ (~x & z);
  endfunction

  function automatic word_t maj(word_t x, word_t y, word_t z);
    return (x & y) ^ (x & z) ^ (y & z);
  endfunction

  assign t1 = h + sigma1(e) + ch(e, f, g) + SHA_K[ctl.round_idx] + i_w;
  assign t2 = sigma0(a) + maj(a, b, c);

  always_ff @(posedge i_clk or negedge i_n_reset) begin
    if (!i_n_reset) begin
      {a, b, c, d, e, f, g, h} <= '0;
    end else if (ctl.load) begin
      {a, b, c, d, e, f, g, h} <= i_hash;  // start from the current chaining value
    end else if (ctl.step) begin
      {b, c, d} <= {a, b, c};
      {f, g, h} <= {e, f, g};
      a <= t1 + t2;
      e <= d + t1;
    end
  end

  assign o_work = {a, b, c, d, e, f, g, h};

  // an X in H or the window would spread through all of a..h from here on
  a_work_known: assert property (@(posedge i_clk) disable iff (!i_n_reset)
    $past(ctl.load) |-> !$isunknown(o_work));

endmodule

`default_nettype wire

// File: include/sha256_cfg.svh
`ifndef SHA256_CFG_SVH
`define SHA256_CFG_SVH

// word size of the hash, every add is modulo 2^32
`define SHA_WORD_W 32

// one message block is sixteen words
`define SHA_BLOCK_WORDS 16

// chaining value H0..H7
`define SHA_DIGEST_WORDS 8

// rounds of the compression function
`define SHA_ROUNDS 64

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the SHA-256 testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module tb_sha256 -Mdir obj_dir -o sim_tb_sha256
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb_sha256 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
